//--- riscv_execute.f
verilog/riscv_ex_pkg.sv
verilog/ex_stage_if.sv
verilog/id_ex_latch.sv
verilog/alu.sv
verilog/branch_decision.sv
verilog/ex_mem_latch.sv
verilog/riscv_execute.sv
testbench/riscv_execute_checker.sv
testbench/tb_riscv_execute.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_riscv_execute \
  -Mdir obj_dir \
  -f riscv_execute.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_riscv_execute)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation PASSED"; then
  exit 0
fi
exit 1

//--- testbench/tb_riscv_execute.sv
`timescale 1ns/100ps

module tb_riscv_execute;

  localparam int PC_W    = 12;
  localparam int TIMEOUT = 40;

  logic clk, rst, in_valid, use_imm, lui, jal, jalr, compare, branch;
  riscv_ex_pkg::word_t    rs1_val, rs2_val, imm, out_result;
  logic [PC_W-1:0]        pc, link_adr, redirect_target;
  riscv_ex_pkg::alu_op_e  alusel;
  riscv_ex_pkg::br_cond_e br_cond;
  logic [4:0]             rd, out_rd;
  logic                   out_valid, redirect;

  // Expected outputs in issue order
  string               exp_name[$];
  int                  exp_cyc[$];
  riscv_ex_pkg::word_t exp_res[$];
  logic [4:0]          exp_rd[$];
  logic                exp_redir[$];
  logic [PC_W-1:0]     exp_tgt[$];

  string test_name = "reset";
  int    cyc = 0;
  int    val_errs = 0;
  int    lat_errs = 0;
  int    other_errs = 0;

  riscv_execute #(.PC_WIDTH(PC_W)) u_riscv_execute (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  ////////////////////
  // Reference model
  ////////////////////

  // Result priority lui, link, compare, then op codes ADD..SRA as 0..7
  function automatic riscv_ex_pkg::word_t model_result(input riscv_ex_pkg::word_t a, b, i,
      input logic [PC_W-1:0] l, input logic [2:0] op, input logic lui_v, jump_v, cmp_v);
    if (lui_v) return i;
    if (jump_v) return {{(32-PC_W){1'b0}}, l};
    // SLTU funct3 is 3'b011
    if (cmp_v && op == 3'b011) return {31'd0, a < b};
    if (cmp_v) return {31'd0, $signed(a) < $signed(b)};
    case (op)
      3'd0: return a + b;
      3'd1: return a - b;
      3'd2: return a & b;
      3'd3: return a | b;
      3'd4: return a ^ b;
      3'd5: return a << b[4:0];
      3'd6: return a >> b[4:0];
      default: return $signed(a) >>> b[4:0];
    endcase
  endfunction

  // Branch funct3 conditions
  function automatic logic model_cond(input logic [2:0] c, input riscv_ex_pkg::word_t a, b);
    case (c)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      3'b111: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  ////////////////////
  // Drivers
  ////////////////////

  task automatic send(input riscv_ex_pkg::word_t a, b2, i, input logic [PC_W-1:0] p, l,
      input logic [2:0] op, input logic ui, lu, jl, jr, cm, br, input logic [2:0] c,
      input logic [4:0] d);
    riscv_ex_pkg::word_t b;
    riscv_ex_pkg::word_t sum;
    b   = ui ? i : b2;
    sum = jr ? a + i : {{(32-PC_W){1'b0}}, p} + i;
    sum[0] = sum[0] && !jr;
    @(posedge clk);
    in_valid <= 1'b1;
    rs1_val  <= a;
    rs2_val  <= b2;
    imm      <= i;
    pc       <= p;
    link_adr <= l;
    alusel   <= riscv_ex_pkg::alu_op_e'(op);
    use_imm  <= ui;
    lui      <= lu;
    jal      <= jl;
    jalr     <= jr;
    compare  <= cm;
    branch   <= br;
    br_cond  <= riscv_ex_pkg::br_cond_e'(c);
    rd       <= d;
    // Sampled on the next edge, then two edges of latency
    exp_name.push_back(test_name);
    exp_cyc.push_back(cyc + 3);
    exp_res.push_back(model_result(a, b, i, l, op, lu, jl || jr, cm));
    exp_rd.push_back(d);
    exp_redir.push_back(jl || jr || (br && model_cond(c, a, b)));
    exp_tgt.push_back(sum[PC_W-1:0]);
  endtask

  // Invalid cycle carrying a jump that must not redirect
  task automatic bubble();
    @(posedge clk);
    in_valid <= 1'b0;
    jal      <= 1'b1;
    branch   <= 1'b1;
    br_cond  <= riscv_ex_pkg::BEQ;
    rs2_val  <= rs1_val;
    use_imm  <= 1'b0;
  endtask

  task automatic pop_expected();
    void'(exp_name.pop_front());
    void'(exp_cyc.pop_front());
    void'(exp_res.pop_front());
    void'(exp_rd.pop_front());
    void'(exp_redir.pop_front());
    void'(exp_tgt.pop_front());
  endtask

  // Idle the inputs and wait until every expected output is seen
  task automatic drain();
    int n;
    n = 0;
    @(posedge clk);
    in_valid <= 1'b0;
    while (exp_res.size() != 0 && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (exp_res.size() != 0) begin
      other_errs++;
      $display("Timeout in %s, %0d outputs never appeared", test_name, exp_res.size());
      while (exp_res.size() != 0) pop_expected();
    end
  endtask

  ////////////////////
  // Monitor
  ////////////////////

  task automatic check_output();
    if (exp_cyc[0] != cyc) begin
      lat_errs++;
      $display("ERR %s cycle expected %0d actual %0d", exp_name[0], exp_cyc[0], cyc);
    end
    if (out_result !== exp_res[0]) begin
      val_errs++;
      $display("ERR %s result expected %h actual %h", exp_name[0], exp_res[0], out_result);
    end
    if (out_rd !== exp_rd[0]) begin
      val_errs++;
      $display("ERR %s rd expected %0d actual %0d", exp_name[0], exp_rd[0], out_rd);
    end
    if (redirect !== exp_redir[0]) begin
      val_errs++;
      $display("ERR %s redirect expected %b actual %b", exp_name[0], exp_redir[0], redirect);
    end
    if (exp_redir[0] && redirect_target !== exp_tgt[0]) begin
      val_errs++;
      $display("ERR %s target expected %h actual %h", exp_name[0], exp_tgt[0],
               redirect_target);
    end
    pop_expected();
  endtask

  // Outputs settle by the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (redirect && !out_valid) begin
        other_errs++;
        $display("Redirect raised without out_valid at cycle %0d", cyc);
      end
      if (out_valid && exp_res.size() == 0) begin
        other_errs++;
        $display("Output seen with no instruction in flight at cycle %0d", cyc);
      end else if (out_valid) begin
        check_output();
      end else if (exp_cyc.size() != 0 && exp_cyc[0] < cyc) begin
        lat_errs++;
        $display("Output of %s due at cycle %0d never appeared", exp_name[0], exp_cyc[0]);
        pop_expected();
      end
    end
  end

  ////////////////////
  // Tests
  ////////////////////

  task automatic test_alu_ops();
    riscv_ex_pkg::word_t a, b, i, p;
    int op;
    int k;
    test_name = "test_alu_ops";
    for (op = 0; op < 8; op++) begin
      for (k = 0; k < 6; k++) begin
        a = $urandom;
        b = $urandom;
        i = $urandom;
        p = $urandom;
        send(a, b, i, p[PC_W-1:0], p[PC_W+11:PC_W], op[2:0], k[0], 1'b0, 1'b0, 1'b0,
             1'b0, 1'b0, 3'b000, p[31:27]);
      end
    end
    drain();
  endtask

  task automatic test_compare();
    riscv_ex_pkg::word_t va[6];
    riscv_ex_pkg::word_t vb[6];
    riscv_ex_pkg::word_t b2;
    int k;
    test_name = "test_compare";
    va = '{32'hffff_ffff, 32'h1, 32'h8000_0000, 32'h7fff_ffff, 32'h5, 32'hffff_fff0};
    vb = '{32'h1, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000, 32'h5, 32'hffff_fff8};
    // Signed then unsigned, odd entries take the immediate
    for (k = 0; k < 6; k++) begin
      // rs2 differs from the immediate when the immediate is selected
      b2 = k[0] ? ~vb[k] : vb[k];
      send(va[k], b2, vb[k], 12'h0, 12'h0, 3'b010, k[0], 1'b0, 1'b0, 1'b0, 1'b1,
           1'b0, 3'b000, 5'd3);
      send(va[k], b2, vb[k], 12'h0, 12'h0, 3'b011, k[0], 1'b0, 1'b0, 1'b0, 1'b1,
           1'b0, 3'b000, 5'd4);
    end
    drain();
  endtask

  task automatic test_overrides();
    riscv_ex_pkg::word_t a, i, p;
    int k;
    test_name = "test_overrides";
    for (k = 0; k < 4; k++) begin
      a = $urandom;
      i = $urandom;
      p = $urandom;
      send(a, a, i, p[PC_W-1:0], p[23:12], 3'b011, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0,
           3'b000, 5'd5);
      send(a, a, i, p[PC_W-1:0], p[23:12], 3'b010, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0,
           3'b000, 5'd1);
      send(a, a, i, p[PC_W-1:0], p[23:12], 3'b011, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0,
           3'b000, 5'd1);
    end
    // Odd sum, bit 0 dropped
    send(32'h101, 32'h0, 32'h10, 12'h0, 12'h44, 3'b000, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0,
         1'b0, 3'b000, 5'd2);
    drain();
  endtask

  task automatic test_branches();
    riscv_ex_pkg::word_t va[3];
    riscv_ex_pkg::word_t vb[3];
    riscv_ex_pkg::word_t i;
    logic [2:0] conds[6];
    int c;
    int k;
    test_name = "test_branches";
    va = '{32'h5, 32'hffff_fffd, 32'h4};
    vb = '{32'h5, 32'h4, 32'hffff_fffd};
    conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    for (c = 0; c < 6; c++) begin
      for (k = 0; k < 3; k++) begin
        i = $urandom;
        send(va[k], vb[k], i, i[31:20], 12'h0, 3'b000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
             1'b1, conds[c], 5'd0);
      end
    end
    // Condition holds on a non-branch
    send(32'h5, 32'h5, 32'h40, 12'h100, 12'h0, 3'b000, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
         1'b0, 3'b000, 5'd6);
    drain();
  endtask

  task automatic test_gaps();
    riscv_ex_pkg::word_t a, i;
    int k;
    test_name = "test_gaps";
    for (k = 0; k < 16; k++) begin
      a = $urandom;
      i = $urandom;
      send(a, i ^ {31'd0, k[1]}, i, i[11:0], a[11:0], a[2:0], 1'b0, 1'b0, 1'b0, 1'b0,
           a[3], a[4], {a[5], 1'b0, a[6]}, a[11:7]);
      bubble();
      if (k[0]) bubble();
    end
    drain();
  endtask

  initial begin
    void'($urandom(32'h1f22));
    rst = 1'b1;
    {in_valid, use_imm, lui, jal, jalr, compare, branch} = '0;
    {rs1_val, rs2_val, imm, pc, link_adr, rd} = '0;
    alusel  = riscv_ex_pkg::ADD;
    br_cond = riscv_ex_pkg::BEQ;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    // Quiet outputs with no input
    repeat (6) begin
      @(negedge clk);
      if (out_valid || redirect) begin
        other_errs++;
        $display("Outputs active after reset with no input");
      end
    end
    test_alu_ops();
    test_compare();
    test_overrides();
    test_branches();
    test_gaps();
    $display("Errors: value %0d, latency %0d, other %0d", val_errs, lat_errs, other_errs);
    if (val_errs + lat_errs + other_errs == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- testbench/riscv_execute_checker.sv
`timescale 1ns/100ps

module riscv_execute_checker #(
  parameter int PC_WIDTH = 12
) (
  input logic                clk,
  input logic                rst,
  input logic                in_valid,
  input logic                jalr,
  input logic                out_valid,
  input logic                redirect,
  input logic [PC_WIDTH-1:0] redirect_target
);

  ////////////////////
  // Reset
  ////////////////////

  // Strobes cleared by every reset edge
  reset_quiet: assert property (@(posedge clk) rst |=> (!out_valid && !redirect))
    else $error("out_valid or redirect high during reset");

  ////////////////////
  // Pipeline timing
  ////////////////////

  // Two register stages from in_valid to out_valid
  valid_latency: assert property (@(posedge clk) disable iff (rst)
    out_valid == $past(in_valid, 2))
    else $error("out_valid does not follow in_valid by two edges");

  // Register-relative jump target is halfword aligned
  jalr_aligned: assert property (@(posedge clk) disable iff (rst)
    $past(in_valid && jalr, 2) |-> !redirect_target[0])
    else $error("redirect_target bit 0 set after a jalr");

endmodule

bind riscv_execute riscv_execute_checker #(.PC_WIDTH(PC_WIDTH)) u_checker (
  .clk             (clk),
  .rst             (rst),
  .in_valid        (in_valid),
  .jalr            (jalr),
  .out_valid       (out_valid),
  .redirect        (redirect),
  .redirect_target (redirect_target)
);

//--- verilog/riscv_execute.sv
`timescale 1ns/100ps

module riscv_execute #(
  parameter int PC_WIDTH = 12
) (
  input  logic                   clk,
  input  logic                   rst,
  // Decoded instruction
  input  logic                   in_valid,
  input  riscv_ex_pkg::word_t    rs1_val,
  input  riscv_ex_pkg::word_t    rs2_val,
  input  riscv_ex_pkg::word_t    imm,
  input  logic [PC_WIDTH-1:0]    pc,
  input  logic [PC_WIDTH-1:0]    link_adr,
  input  riscv_ex_pkg::alu_op_e  alusel,
  input  logic                   use_imm,
  input  logic                   lui,
  input  logic                   jal,
  input  logic                   jalr,
  input  logic                   compare,
  input  logic                   branch,
  input  riscv_ex_pkg::br_cond_e br_cond,
  input  logic [4:0]             rd,
  // EX/MEM outputs
  output logic                   out_valid,
  output riscv_ex_pkg::word_t    out_result,
  output logic [4:0]             out_rd,
  output logic                   redirect,
  output logic [PC_WIDTH-1:0]    redirect_target
);

  // Execute unit outputs into EX/MEM
  riscv_ex_pkg::word_t alu_res;
  logic                br_taken;
  logic [PC_WIDTH-1:0] br_target;

  ////////////////////
  // ID/EX stage
  ////////////////////

  ex_stage_if #(.PC_WIDTH(PC_WIDTH)) ex_bus ();

  id_ex_latch #(.PC_WIDTH(PC_WIDTH)) u_id_ex_latch (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .rs1_val  (rs1_val),
    .rs2_val  (rs2_val),
    .imm      (imm),
    .pc       (pc),
    .link_adr (link_adr),
    .alusel   (alusel),
    .use_imm  (use_imm),
    .lui      (lui),
    .jal      (jal),
    .jalr     (jalr),
    .compare  (compare),
    .branch   (branch),
    .br_cond  (br_cond),
    .rd       (rd),
    .ex       (ex_bus.latch)
  );

  ////////////////////
  // Execute units
  ////////////////////

  // Compare flag is already folded into the result
  alu u_alu (
    .ex       (ex_bus.exec),
    .res      (alu_res),
    .comp_res ()
  );

  branch_decision #(.PC_WIDTH(PC_WIDTH)) u_branch_decision (
    .ex     (ex_bus.exec),
    .taken  (br_taken),
    .target (br_target)
  );

  ////////////////////
  // EX/MEM stage
  ////////////////////

  ex_mem_latch #(.PC_WIDTH(PC_WIDTH)) u_ex_mem_latch (
    .clk             (clk),
    .rst             (rst),
    .ex              (ex_bus.wb),
    .res             (alu_res),
    .taken           (br_taken),
    .target          (br_target),
    .out_valid       (out_valid),
    .out_result      (out_result),
    .out_rd          (out_rd),
    .redirect        (redirect),
    .redirect_target (redirect_target)
  );

endmodule

//--- verilog/ex_mem_latch.sv
`timescale 1ns/100ps

module ex_mem_latch #(
  parameter int PC_WIDTH = 12
) (
  input  logic                clk,
  input  logic                rst,
  ex_stage_if.wb              ex,
  input  riscv_ex_pkg::word_t res,
  input  logic                taken,
  input  logic [PC_WIDTH-1:0] target,
  output logic                out_valid,
  output riscv_ex_pkg::word_t out_result,
  output logic [4:0]          out_rd,
  output logic                redirect,
  output logic [PC_WIDTH-1:0] redirect_target
);

  ////////////////////
  // Strobes
  ////////////////////

  // Bubbles never raise redirect
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      redirect  <= 1'b0;
    end else begin
      out_valid <= ex.valid;
      redirect  <= ex.valid && taken;
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  // Held across bubbles
  always_ff @(posedge clk) begin
    if (ex.valid) begin
      out_result      <= res;
      out_rd          <= ex.rd;
      redirect_target <= target;
    end
  end

endmodule

//--- verilog/branch_decision.sv
`timescale 1ns/100ps

module branch_decision #(
  parameter int PC_WIDTH = 12
) (
  ex_stage_if.exec            ex,
  output logic                taken,
  output logic [PC_WIDTH-1:0] target
);

  // Condition flags on rs1 against the register operand
  logic eq;
  logic lt_signed;
  logic lt_unsigned;
  logic cond_true;

  // Full width target sums
  riscv_ex_pkg::word_t pc_sum;
  riscv_ex_pkg::word_t jalr_sum;

  ////////////////////
  // Conditions
  ////////////////////

  assign eq          = (ex.rs1_val == ex.op_b);
  assign lt_signed   = $signed(ex.rs1_val) < $signed(ex.op_b);
  assign lt_unsigned = ex.rs1_val < ex.op_b;

  // Each odd code is the inverse of the one before
  always_comb begin
    case (ex.br_cond)
      riscv_ex_pkg::BEQ:  cond_true = eq;
      riscv_ex_pkg::BNE:  cond_true = !eq;
      riscv_ex_pkg::BLT:  cond_true = lt_signed;
      riscv_ex_pkg::BGE:  cond_true = !lt_signed;
      riscv_ex_pkg::BLTU: cond_true = lt_unsigned;
      riscv_ex_pkg::BGEU: cond_true = !lt_unsigned;
      // Unused codes never branch
      default:            cond_true = 1'b0;
    endcase
  end

  // Jumps always redirect
  assign taken = ex.jal || ex.jalr || (ex.branch && cond_true);

  ////////////////////
  // Target
  ////////////////////

  // PC-relative for jal and branches
  assign pc_sum   = riscv_ex_pkg::word_t'(ex.pc) + ex.imm;

  // Register-relative for jalr
  assign jalr_sum = ex.rs1_val + ex.imm;

  // Truncated to the PC width, jalr drops bit 0
  assign target = ex.jalr ? {jalr_sum[PC_WIDTH-1:1], 1'b0} : pc_sum[PC_WIDTH-1:0];

endmodule

//--- verilog/alu.sv
`timescale 1ns/100ps

module alu (
  ex_stage_if.exec             ex,
  output riscv_ex_pkg::word_t  res,
  output logic                 comp_res
);

  // Raw operation result
  riscv_ex_pkg::word_t s;

  // Link address widened to a full word
  riscv_ex_pkg::word_t link_ext;

  // Less-than in both flavours
  logic lt_signed;
  logic lt_unsigned;

  ////////////////////
  // Operation
  ////////////////////

  always_comb begin
    case (ex.alusel)
      riscv_ex_pkg::ADD: s = ex.op_a + ex.op_b;
      riscv_ex_pkg::SUB: s = ex.op_a - ex.op_b;
      riscv_ex_pkg::AND: s = ex.op_a & ex.op_b;
      riscv_ex_pkg::OR:  s = ex.op_a | ex.op_b;
      riscv_ex_pkg::XOR: s = ex.op_a ^ ex.op_b;
      // Shift amount is the low 5 bits
      riscv_ex_pkg::SLL: s = ex.op_a << ex.op_b[4:0];
      riscv_ex_pkg::SRL: s = ex.op_a >> ex.op_b[4:0];
      // Arithmetic shift keeps the sign
      riscv_ex_pkg::SRA: s = $signed(ex.op_a) >>> ex.op_b[4:0];
      default:           s = ex.op_a + ex.op_b;
    endcase
  end

  ////////////////////
  // Compare
  ////////////////////

  assign lt_signed   = $signed(ex.op_a) < $signed(ex.op_b);
  assign lt_unsigned = ex.op_a < ex.op_b;

  // SLTU when flagged, SLT otherwise
  assign comp_res = ex.unsigned_cmp ? lt_unsigned : lt_signed;

  ////////////////////
  // Result overrides
  ////////////////////

  // Zero extension of the narrow link address
  assign link_ext = riscv_ex_pkg::word_t'(ex.link_adr);

  // Priority: LUI, then jump link, then compare, then ALU
  // A compare gives exactly 1 or 0
  assign res = ex.lui                ? ex.imm :
               (ex.jal || ex.jalr)   ? link_ext :
               ex.compare            ? riscv_ex_pkg::word_t'(comp_res) :
                                       s;

endmodule

//--- verilog/id_ex_latch.sv
`timescale 1ns/100ps

module id_ex_latch #(
  parameter int PC_WIDTH = 12
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid,
  input  riscv_ex_pkg::word_t    rs1_val,
  input  riscv_ex_pkg::word_t    rs2_val,
  input  riscv_ex_pkg::word_t    imm,
  input  logic [PC_WIDTH-1:0]    pc,
  input  logic [PC_WIDTH-1:0]    link_adr,
  input  riscv_ex_pkg::alu_op_e  alusel,
  input  logic                   use_imm,
  input  logic                   lui,
  input  logic                   jal,
  input  logic                   jalr,
  input  logic                   compare,
  input  logic                   branch,
  input  riscv_ex_pkg::br_cond_e br_cond,
  input  logic [4:0]             rd,
  ex_stage_if.latch              ex
);

  ////////////////////
  // Operand select
  ////////////////////

  // Second operand from immediate or rs2
  riscv_ex_pkg::word_t op_b_next;

  // Compare signedness from the alusel code
  logic                unsigned_next;

  assign op_b_next     = use_imm ? imm : rs2_val;
  assign unsigned_next = (alusel == riscv_ex_pkg::SLTU_SEL);

  ////////////////////
  // Control register
  ////////////////////

  // Valid and the flags that steer result and redirect
  always_ff @(posedge clk) begin
    if (rst) begin
      ex.valid   <= 1'b0;
      ex.lui     <= 1'b0;
      ex.jal     <= 1'b0;
      ex.jalr    <= 1'b0;
      ex.compare <= 1'b0;
      ex.branch  <= 1'b0;
    end else begin
      ex.valid   <= in_valid;
      ex.lui     <= lui;
      ex.jal     <= jal;
      ex.jalr    <= jalr;
      ex.compare <= compare;
      ex.branch  <= branch;
    end
  end

  ////////////////////
  // Payload register
  ////////////////////

  // Loaded every edge, bubbles carry don't-care data
  always_ff @(posedge clk) begin
    // Operands
    ex.op_a         <= rs1_val;
    ex.op_b         <= op_b_next;
    ex.rs1_val      <= rs1_val;
    ex.imm          <= imm;
    // Addresses
    ex.pc           <= pc;
    ex.link_adr     <= link_adr;
    // Operation select
    ex.alusel       <= alusel;
    ex.br_cond      <= br_cond;
    ex.unsigned_cmp <= unsigned_next;
    // Destination register
    ex.rd           <= rd;
  end

endmodule

//--- verilog/ex_stage_if.sv
`timescale 1ns/100ps

interface ex_stage_if #(
  parameter int PC_WIDTH = 12
);

  // Instruction held in the ID/EX register
  logic                     valid;
  riscv_ex_pkg::word_t      op_a;
  riscv_ex_pkg::word_t      op_b;
  riscv_ex_pkg::word_t      rs1_val;
  riscv_ex_pkg::word_t      imm;
  logic [PC_WIDTH-1:0]      pc;
  logic [PC_WIDTH-1:0]      link_adr;
  riscv_ex_pkg::alu_op_e    alusel;
  riscv_ex_pkg::br_cond_e   br_cond;

  // Decoder control flags
  logic                     lui;
  logic                     jal;
  logic                     jalr;
  logic                     compare;
  logic                     branch;
  logic                     unsigned_cmp;
  logic [4:0]               rd;

  // ID/EX register side
  modport latch (
    output valid, op_a, op_b, rs1_val, imm, pc, link_adr, alusel, br_cond,
           lui, jal, jalr, compare, branch, unsigned_cmp, rd
  );

  // ALU and branch unit
  modport exec (
    input op_a, op_b, rs1_val, imm, pc, link_adr, alusel, br_cond,
          lui, jal, jalr, compare, branch, unsigned_cmp
  );

  // EX/MEM register side
  modport wb (
    input valid, rd, jal
  );

endinterface

//--- verilog/riscv_ex_pkg.sv
package riscv_ex_pkg;

  ////////////////////
  // Data width
  ////////////////////

  // Integer register width, RV32I
  parameter int XLEN = 32;

  // One machine word
  typedef logic [XLEN-1:0] word_t;

  ////////////////////
  // ALU operations
  ////////////////////

  // Select codes as the decoder emits them
  typedef enum logic [2:0] {
    ADD = 3'b000,
    SUB = 3'b001,
    AND = 3'b010,
    OR  = 3'b011,
    XOR = 3'b100,
    SLL = 3'b101,
    SRL = 3'b110,
    SRA = 3'b111
  } alu_op_e;

  // Compare instructions reuse alusel
  // Code 3'b011 means SLTU, any other code means SLT
  // Same low bits as the funct3 values of SLT and SLTU
  parameter alu_op_e SLTU_SEL = OR;

  ////////////////////
  // Branch conditions
  ////////////////////

  // Codes follow the branch funct3 field
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_cond_e;

endpackage
